/* files.f */
design/hps_cmd_pkg.sv
design/hps_file_pkg.sv
design/uio_decoder.sv
design/ps2_key_decoder.sv
design/file_download.sv
design/hps_io.sv
verif/tb_hps_io.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_hps_io
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_hps_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hps_io;

	localparam bit wide = 1'b0;
	localparam int dw = wide ? 16 : 8;
	localparam int aw = hps_file_pkg::ioctl_addr_w;
	localparam int num_key_frames = 12;
	localparam int num_dl_words = 16;

	// enable edges, two cycles per word, three tail cycles
	function automatic int frame_len(input int words);
		return 2 * words + 5;
	endfunction

	localparam int run_cycles = 16 + frame_len(2) + 2 * frame_len(3) + 2 * frame_len(9) + 2
		+ num_key_frames * frame_len(4) + frame_len(5) + frame_len(7) + frame_len(9)
		+ frame_len(4) + frame_len(2) + frame_len(4) + frame_len(num_dl_words + 1)
		+ frame_len(2) + frame_len(5);
	localparam int timeout_cycles = 2 * run_cycles;

	logic                                 clk_sys;
	logic                                 rst_n;
	logic                                 io_enable;
	logic                                 io_strobe;
	logic                                 fp_enable;
	logic [hps_cmd_pkg::word_w-1:0]       io_din;
	logic [hps_cmd_pkg::word_w-1:0]       io_dout;
	logic [hps_cmd_pkg::status_w-1:0]     status_in;
	logic                                 status_set;
	logic [hps_cmd_pkg::status_w-1:0]     status;
	logic [hps_cmd_pkg::joy_w-1:0]        joystick_0;
	logic [hps_cmd_pkg::joy_w-1:0]        joystick_1;
	logic [1:0]                           buttons;
	logic                                 forced_scandoubler;
	logic                                 direct_video;
	logic [hps_cmd_pkg::key_code_w-1:0]   ps2_key;
	logic                                 ioctl_download;
	logic                                 ioctl_wr;
	logic [15:0]                          ioctl_index;
	logic [aw-1:0]                        ioctl_addr;
	logic [dw-1:0]                        ioctl_dout;

	logic [31:0]   lfsr;
	logic [10:0]   exp_key;
	logic [15:0]   tx_words[$];
	logic [15:0]   dout_log[$];
	logic [aw-1:0] exp_wr_addr[$];
	logic [dw-1:0] exp_wr_data[$];
	logic [15:0]   stat_words[8];
	int            wr_count;
	int            err_cnt;
	int            test_err_base;
	int            tests_run;
	int            tests_failed;
	int            cycle_cnt;

	hps_io #(
		.wide (wide)
	) i_hps_io (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.status_in          (status_in),
		.status_set         (status_set),
		.status             (status),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_wr           (ioctl_wr),
		.ioctl_index        (ioctl_index),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//////////////////////////////
	// random source and reference models

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return val;
	endfunction

	// expected event from what the frame describes
	function automatic logic [10:0] key_ref(input logic released, input logic extended,
		input logic [7:0] code, input logic toggle);
		return {~toggle, ~released, extended, code};
	endfunction

	function automatic logic [127:0] status_ref(input logic [15:0] words[8]);
		logic [127:0] val;
		for (int n = 0; n < 8; n++)
			val[16*n +: 16] = words[n];
		return val;
	endfunction

	function automatic logic [aw-1:0] addr_ref(input logic [aw-1:0] start, input int n);
		return start + aw'(wide ? 2 * n : n);
	endfunction

	//////////////////////////////
	// bus driving and reporting

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
		err_cnt++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt == test_err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	// io_dout is logged in the idle cycle after each strobe
	task automatic send_frame(input bit file_port);
		dout_log.delete();
		@(negedge clk_sys);
		if (file_port)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		foreach (tx_words[i]) begin
			@(negedge clk_sys);
			io_strobe = 1'b1;
			io_din    = tx_words[i];
			@(negedge clk_sys);
			io_strobe = 1'b0;
			dout_log.push_back(io_dout);
		end
		@(negedge clk_sys);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (3) @(negedge clk_sys);
		tx_words.delete();
	endtask

	task automatic start_key_frame();
		tx_words.push_back(hps_cmd_pkg::cmd_kbd);
	endtask

	task automatic add_key_byte(input logic [7:0] b);
		tx_words.push_back({8'h00, b});
	endtask

	task automatic finish_key_frame(input logic released, input logic extended,
		input logic [7:0] code);
		send_frame(1'b0);
		exp_key = key_ref(released, extended, code, exp_key[10]);
		if (ps2_key !== exp_key)
			report_mismatch("ps2_key", 128'(ps2_key), 128'(exp_key));
	endtask

	// write pulses against the queued address and data
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			wr_count++;
			if (exp_wr_addr.size() == 0) begin
				$display("write pulse at t=%0t without a pending data word", $time);
				err_cnt++;
			end else begin
				if (ioctl_addr !== exp_wr_addr[0])
					report_mismatch("ioctl_addr", 128'(ioctl_addr), 128'(exp_wr_addr[0]));
				if (ioctl_dout !== exp_wr_data[0])
					report_mismatch("ioctl_dout", 128'(ioctl_dout), 128'(exp_wr_data[0]));
				void'(exp_wr_addr.pop_front());
				void'(exp_wr_data.pop_front());
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt <= timeout_cycles) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles, tests did not finish", cycle_cnt);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////
	// test sequence
	initial begin
		logic [15:0]   cfg_word;
		logic [15:0]   lo;
		logic [15:0]   hi;
		logic [15:0]   w;
		logic [127:0]  cap;
		logic [3:0]    exp_flag;
		logic [aw-1:0] start_addr;
		logic [1:0]    kind;
		rst_n      = 1'b0;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		lfsr       = 32'hac0a;
		exp_key    = '0;
		exp_flag   = '0;
		wr_count   = 0;
		err_cnt    = 0;
		test_err_base = 0;
		tests_run  = 0;
		tests_failed = 0;
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;

		cfg_word = 16'(rand_bits(16));
		tx_words.push_back(hps_cmd_pkg::cmd_config);
		tx_words.push_back(cfg_word);
		send_frame(1'b0);
		if (buttons !== cfg_word[1:0])
			report_mismatch("buttons", 128'(buttons), 128'(cfg_word[1:0]));
		if (forced_scandoubler !== cfg_word[4])
			report_mismatch("forced_scandoubler", 128'(forced_scandoubler), 128'(cfg_word[4]));
		if (direct_video !== cfg_word[10])
			report_mismatch("direct_video", 128'(direct_video), 128'(cfg_word[10]));
		end_test("config word");

		for (int j = 0; j < 2; j++) begin
			lo = 16'(rand_bits(16));
			hi = 16'(rand_bits(16));
			tx_words.push_back(j == 0 ? hps_cmd_pkg::cmd_joy0 : hps_cmd_pkg::cmd_joy1);
			tx_words.push_back(lo);
			tx_words.push_back(hi);
			send_frame(1'b0);
			if ((j == 0 ? joystick_0 : joystick_1) !== {hi, lo})
				report_mismatch(j == 0 ? "joystick_0" : "joystick_1",
					128'(j == 0 ? joystick_0 : joystick_1), 128'({hi, lo}));
		end
		end_test("joysticks");

		tx_words.push_back(hps_cmd_pkg::cmd_status);
		for (int n = 0; n < 8; n++) begin
			stat_words[n] = 16'(rand_bits(16));
			tx_words.push_back(stat_words[n]);
		end
		send_frame(1'b0);
		if (status !== status_ref(stat_words))
			report_mismatch("status", status, status_ref(stat_words));
		// core side pushes a snapshot, then changes its input
		@(negedge clk_sys);
		status_in  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
		status_set = 1'b1;
		cap        = status_in;
		exp_flag   = exp_flag + 4'd1;
		@(negedge clk_sys);
		status_set = 1'b0;
		status_in  = ~cap;
		tx_words.push_back(hps_cmd_pkg::cmd_status_set);
		for (int n = 0; n < 8; n++)
			tx_words.push_back(16'h0000);
		send_frame(1'b0);
		if (dout_log[0] !== {8'h00, hps_cmd_pkg::status_set_tag, exp_flag})
			report_mismatch("io_dout", 128'(dout_log[0]),
				128'({8'h00, hps_cmd_pkg::status_set_tag, exp_flag}));
		for (int n = 1; n <= 8; n++) begin
			if (dout_log[n] !== cap[16*(n-1) +: 16])
				report_mismatch("io_dout", 128'(dout_log[n]), 128'(cap[16*(n-1) +: 16]));
		end
		end_test("status");

		for (int k = 0; k < num_key_frames; k++) begin
			kind = 2'(rand_bits(2));
			w    = 16'(rand_bits(8));
			start_key_frame();
			if (kind[1])
				add_key_byte(8'he0);
			if (kind[0])
				add_key_byte(8'hf0);
			add_key_byte(w[7:0]);
			finish_key_frame(kind[0], kind[1], w[7:0]);
		end
		start_key_frame();
		add_key_byte(8'he0);
		add_key_byte(8'h12);
		add_key_byte(8'he0);
		add_key_byte(8'h7c);
		finish_key_frame(1'b0, 1'b1, 8'h7c);
		start_key_frame();
		add_key_byte(8'he0);
		add_key_byte(8'hf0);
		add_key_byte(8'h7c);
		add_key_byte(8'he0);
		add_key_byte(8'hf0);
		add_key_byte(8'h12);
		finish_key_frame(1'b1, 1'b1, 8'h7c);
		start_key_frame();
		add_key_byte(8'he1);
		add_key_byte(8'h14);
		add_key_byte(8'h77);
		add_key_byte(8'he1);
		add_key_byte(8'hf0);
		add_key_byte(8'h14);
		add_key_byte(8'hf0);
		add_key_byte(8'h77);
		finish_key_frame(1'b0, 1'b1, 8'h77);
		// skipped frame keeps the last event
		start_key_frame();
		tx_words.push_back(16'h001c);
		tx_words.push_back({hps_cmd_pkg::skip_marker, 8'h00});
		tx_words.push_back(16'h0032);
		send_frame(1'b0);
		if (ps2_key !== exp_key)
			report_mismatch("ps2_key", 128'(ps2_key), 128'(exp_key));
		end_test("keyboard");

		w = 16'(rand_bits(16));
		tx_words.push_back(hps_file_pkg::fio_file_index);
		tx_words.push_back(w);
		send_frame(1'b1);
		if (ioctl_index !== w)
			report_mismatch("ioctl_index", 128'(ioctl_index), 128'(w));
		start_addr = aw'(rand_bits(aw));
		tx_words.push_back(hps_file_pkg::fio_file_tx);
		tx_words.push_back(16'h0001);
		tx_words.push_back(start_addr[15:0]);
		tx_words.push_back({5'b0, start_addr[aw-1:16]});
		send_frame(1'b1);
		if (ioctl_download !== 1'b1)
			report_mismatch("ioctl_download", 128'(ioctl_download), 128'(1));
		if (ioctl_addr !== start_addr)
			report_mismatch("ioctl_addr", 128'(ioctl_addr), 128'(start_addr));
		tx_words.push_back(hps_file_pkg::fio_file_tx_dat);
		for (int i = 0; i < num_dl_words; i++) begin
			w = 16'(rand_bits(16));
			tx_words.push_back(w);
			exp_wr_addr.push_back(addr_ref(start_addr, i));
			exp_wr_data.push_back(w[dw-1:0]);
		end
		wr_count = 0;
		send_frame(1'b1);
		if (wr_count != num_dl_words)
			report_mismatch("write count", 128'(wr_count), 128'(num_dl_words));
		tx_words.push_back(hps_file_pkg::fio_file_tx);
		tx_words.push_back(16'h0000);
		send_frame(1'b1);
		if (ioctl_download !== 1'b0)
			report_mismatch("ioctl_download", 128'(ioctl_download), 128'(0));
		// no download running, so these words must not write
		tx_words.push_back(hps_file_pkg::fio_file_tx_dat);
		for (int i = 0; i < 4; i++)
			tx_words.push_back(16'(rand_bits(16)));
		wr_count = 0;
		send_frame(1'b1);
		if (wr_count != 0)
			report_mismatch("write count", 128'(wr_count), 128'(0));
		end_test("download");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/hps_io.sv */
`timescale 1ns/1ps
`default_nettype none

module hps_io #(
	parameter bit wide = 1'b0
) (
	input  wire logic                                  clk_sys,
	input  wire logic                                  rst_n,
	input  wire logic                                  io_enable,
	input  wire logic                                  io_strobe,
	input  wire logic                                  fp_enable,
	input  wire logic [hps_cmd_pkg::word_w-1:0]        io_din,
	output logic      [hps_cmd_pkg::word_w-1:0]        io_dout,
	input  wire logic [hps_cmd_pkg::status_w-1:0]      status_in,
	input  wire logic                                  status_set,
	output logic      [hps_cmd_pkg::status_w-1:0]      status,
	output logic      [hps_cmd_pkg::joy_w-1:0]         joystick_0,
	output logic      [hps_cmd_pkg::joy_w-1:0]         joystick_1,
	output logic      [1:0]                            buttons,
	output logic                                       forced_scandoubler,
	output logic                                       direct_video,
	output logic      [hps_cmd_pkg::key_code_w-1:0]    ps2_key,
	output logic                                       ioctl_download,
	output logic                                       ioctl_wr,
	output logic      [15:0]                           ioctl_index,
	output logic      [hps_file_pkg::ioctl_addr_w-1:0] ioctl_addr,
	output logic      [(wide ? 16 : 8)-1:0]            ioctl_dout
);

	logic [hps_cmd_pkg::word_w-1:0] cfg;
	logic                           kbd_start;
	logic                           kbd_byte_valid;
	logic [7:0]                     kbd_byte;
	logic                           kbd_end;

	// config word fields used by the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	uio_decoder i_uio_decoder (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.io_enable      (io_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.io_dout        (io_dout),
		.status_in      (status_in),
		.status_set     (status_set),
		.status         (status),
		.joystick_0     (joystick_0),
		.joystick_1     (joystick_1),
		.cfg            (cfg),
		.kbd_start      (kbd_start),
		.kbd_byte_valid (kbd_byte_valid),
		.kbd_byte       (kbd_byte),
		.kbd_end        (kbd_end)
	);

	ps2_key_decoder i_ps2_key_decoder (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.kbd_start      (kbd_start),
		.kbd_byte_valid (kbd_byte_valid),
		.kbd_byte       (kbd_byte),
		.kbd_end        (kbd_end),
		.ps2_key        (ps2_key)
	);

	file_download #(
		.wide (wide)
	) i_file_download (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

`default_nettype wire

/* design/file_download.sv */
`timescale 1ns/1ps
`default_nettype none

module file_download #(
	parameter bit wide = 1'b0
) (
	input  wire logic                                  clk_sys,
	input  wire logic                                  rst_n,
	input  wire logic                                  fp_enable,
	input  wire logic                                  io_strobe,
	input  wire logic [15:0]                           io_din,
	output logic                                       ioctl_download,
	output logic                                       ioctl_wr,
	output logic      [15:0]                           ioctl_index,
	output logic      [hps_file_pkg::ioctl_addr_w-1:0] ioctl_addr,
	output logic      [(wide ? 16 : 8)-1:0]            ioctl_dout
);

	localparam int dw = wide ? 16 : 8;
	localparam int aw = hps_file_pkg::ioctl_addr_w;
	localparam logic [aw-1:0] addr_step = wide ? aw'(2) : aw'(1);

	logic [15:0]   cmd;
	logic          has_cmd;
	logic [1:0]    arg_cnt;
	logic [aw-1:0] addr;
	logic          wr_pend;
	logic          arg_stb;
	logic          tx_ctl;
	logic          tx_dat;
	logic          idx_ld;
	logic          tx_start;
	logic          tx_stop;

	assign arg_stb  = fp_enable && io_strobe && has_cmd;
	assign tx_ctl   = arg_stb && (cmd == hps_file_pkg::fio_file_tx);
	assign tx_dat   = arg_stb && (cmd == hps_file_pkg::fio_file_tx_dat) && ioctl_download;
	assign idx_ld   = arg_stb && (cmd == hps_file_pkg::fio_file_index);
	// first tx argument selects start or stop
	assign tx_start = tx_ctl && (arg_cnt == 2'd0) && (io_din[7:0] != 8'h00);
	assign tx_stop  = tx_ctl && (arg_cnt == 2'd0) && (io_din[7:0] == 8'h00);

	//////////////////////////////
	// framing and write strobe
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			arg_cnt        <= '0;
			ioctl_download <= 1'b0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			// one stage of delay so addr and data settle before the pulse
			wr_pend  <= tx_dat;
			ioctl_wr <= wr_pend;

			if (!fp_enable) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					arg_cnt <= '0;
				end else if (arg_cnt != 2'd3) begin
					arg_cnt <= arg_cnt + 2'd1;
				end
			end

			if (tx_start)
				ioctl_download <= 1'b1;
			else if (tx_stop)
				ioctl_download <= 1'b0;
		end
	end

	//////////////////////////////
	// index, address and data
	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe && !has_cmd)
			cmd <= io_din;
		if (idx_ld)
			ioctl_index <= io_din;
		if (tx_start)
			addr <= '0;
		// stop leaves the end address visible
		if (tx_stop && ioctl_download)
			ioctl_addr <= addr;
		if (tx_ctl && (arg_cnt == 2'd1)) begin
			ioctl_addr[15:0] <= io_din;
			addr[15:0]       <= io_din;
		end
		if (tx_ctl && (arg_cnt == 2'd2)) begin
			ioctl_addr[aw-1:16] <= io_din[aw-17:0];
			addr[aw-1:16]       <= io_din[aw-17:0];
		end
		if (tx_dat) begin
			ioctl_addr <= addr;
			ioctl_dout <= io_din[dw-1:0];
			addr       <= addr + addr_step;
		end
	end

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download);

endmodule

`default_nettype wire

/* design/ps2_key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire logic                               clk_sys,
	input  wire logic                               rst_n,
	input  wire logic                               kbd_start,
	input  wire logic                               kbd_byte_valid,
	input  wire logic [7:0]                         kbd_byte,
	input  wire logic                               kbd_end,
	output logic      [hps_cmd_pkg::key_code_w-1:0] ps2_key
);

	logic [31:0]                      key_raw;
	logic                             pressed;
	logic                             extended;
	logic [hps_cmd_pkg::key_code_w-1:0] key_next;

	// release has F0 just before the code, prefix moves one byte back
	assign pressed  = (key_raw[15:8] != hps_cmd_pkg::kbd_release_prefix);
	assign extended = pressed ? (key_raw[15:8] == hps_cmd_pkg::kbd_ext_prefix) :
		(key_raw[23:16] == hps_cmd_pkg::kbd_ext_prefix);

	always_comb begin
		key_next = ps2_key;
		key_next[hps_cmd_pkg::key_toggle_bit]         = ~ps2_key[hps_cmd_pkg::key_toggle_bit];
		key_next[hps_cmd_pkg::key_pressed_bit]        = pressed;
		key_next[hps_cmd_pkg::key_ext_bit]            = extended;
		key_next[hps_cmd_pkg::key_ext_bit-1:0]        = key_raw[7:0];
		case (key_raw)
			// print screen make
			32'he012e07c: key_next[hps_cmd_pkg::key_toggle_bit-1:0] = 10'h37c;
			// print screen break
			32'h7ce0f012: key_next[hps_cmd_pkg::key_toggle_bit-1:0] = 10'h17c;
			// pause, make only
			32'hf014f077: key_next[hps_cmd_pkg::key_toggle_bit-1:0] = 10'h377;
			default: ;
		endcase
	end

	//////////////////////////////
	// byte collection
	always_ff @(posedge clk_sys) begin
		if (kbd_start)
			key_raw <= '0;
		else if (kbd_byte_valid)
			key_raw <= {key_raw[23:0], kbd_byte};
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			ps2_key <= '0;
		else if (kbd_end)
			ps2_key <= key_next;
	end

	a_toggle_on_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(ps2_key[hps_cmd_pkg::key_toggle_bit]) |-> $past(kbd_end));

endmodule

`default_nettype wire

/* design/uio_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module uio_decoder (
	input  wire logic                             clk_sys,
	input  wire logic                             rst_n,
	input  wire logic                             io_enable,
	input  wire logic                             io_strobe,
	input  wire logic [hps_cmd_pkg::word_w-1:0]   io_din,
	output logic      [hps_cmd_pkg::word_w-1:0]   io_dout,
	input  wire logic [hps_cmd_pkg::status_w-1:0] status_in,
	input  wire logic                             status_set,
	output logic      [hps_cmd_pkg::status_w-1:0] status,
	output logic      [hps_cmd_pkg::joy_w-1:0]    joystick_0,
	output logic      [hps_cmd_pkg::joy_w-1:0]    joystick_1,
	output logic      [hps_cmd_pkg::word_w-1:0]   cfg,
	output logic                                  kbd_start,
	output logic                                  kbd_byte_valid,
	output logic      [7:0]                       kbd_byte,
	output logic                                  kbd_end
);

	localparam int cnt_w        = 4;
	localparam int status_words = hps_cmd_pkg::status_w / hps_cmd_pkg::word_w;
	localparam int idx_w        = $clog2(status_words);
	localparam logic [cnt_w-1:0] cnt_max = '1;

	logic [hps_cmd_pkg::word_w-1:0]   cmd;
	logic [cnt_w-1:0]                 word_cnt;
	logic [idx_w-1:0]                 word_idx;
	logic                             in_range;
	logic                             skip;
	logic                             arg_skip;
	logic                             status_set_d;
	logic                             status_set_rise;
	logic [3:0]                       stat_flag;
	logic [hps_cmd_pkg::status_w-1:0] status_req;

	// argument word n maps to slot n-1
	assign word_idx        = word_cnt[idx_w-1:0] - 1'b1;
	assign in_range        = (word_cnt != '0) && (word_cnt <= cnt_w'(status_words));
	assign arg_skip        = (io_din[15:8] == hps_cmd_pkg::skip_marker);
	assign status_set_rise = status_set && !status_set_d;

	//////////////////////////////
	// frame decode
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd            <= '0;
			word_cnt       <= '0;
			skip           <= 1'b0;
			io_dout        <= '0;
			cfg            <= '0;
			joystick_0     <= '0;
			joystick_1     <= '0;
			status         <= '0;
			status_set_d   <= 1'b0;
			stat_flag      <= '0;
			kbd_start      <= 1'b0;
			kbd_byte_valid <= 1'b0;
			kbd_end        <= 1'b0;
		end else begin
			kbd_start      <= 1'b0;
			kbd_byte_valid <= 1'b0;
			kbd_end        <= 1'b0;

			status_set_d <= status_set;
			if (status_set_rise)
				stat_flag <= stat_flag + 4'd1;

			if (!io_enable) begin
				// frame closed, key event only if nothing was skipped
				if ((cmd == hps_cmd_pkg::cmd_kbd) && !skip)
					kbd_end <= 1'b1;
				cmd      <= '0;
				word_cnt <= '0;
				skip     <= 1'b0;
			end else if (io_strobe) begin
				io_dout <= '0;
				if (word_cnt != cnt_max)
					word_cnt <= word_cnt + 1'b1;

				if (word_cnt == '0) begin
					cmd       <= io_din;
					kbd_start <= (io_din == hps_cmd_pkg::cmd_kbd);
					if (io_din == hps_cmd_pkg::cmd_status_set)
						io_dout <= {{(hps_cmd_pkg::word_w-8){1'b0}},
							hps_cmd_pkg::status_set_tag, stat_flag};
				end else begin
					case (cmd)
						hps_cmd_pkg::cmd_config: cfg <= io_din;
						hps_cmd_pkg::cmd_joy0: begin
							if (word_cnt == cnt_w'(1))
								joystick_0[15:0] <= io_din;
							else if (word_cnt == cnt_w'(2))
								joystick_0[31:16] <= io_din;
						end
						hps_cmd_pkg::cmd_joy1: begin
							if (word_cnt == cnt_w'(1))
								joystick_1[15:0] <= io_din;
							else if (word_cnt == cnt_w'(2))
								joystick_1[31:16] <= io_din;
						end
						hps_cmd_pkg::cmd_kbd: begin
							if (arg_skip)
								skip <= 1'b1;
							else if (!skip)
								kbd_byte_valid <= 1'b1;
						end
						hps_cmd_pkg::cmd_status: begin
							if (in_range)
								status[word_idx*hps_cmd_pkg::word_w +: hps_cmd_pkg::word_w]
									<= io_din;
						end
						hps_cmd_pkg::cmd_status_set: begin
							if (in_range)
								io_dout <= status_req[word_idx*hps_cmd_pkg::word_w +:
									hps_cmd_pkg::word_w];
						end
						default: ;
					endcase
				end
			end
		end
	end

	// snapshot of the core status and the last keyboard byte
	always_ff @(posedge clk_sys) begin
		if (status_set_rise)
			status_req <= status_in;
		if (io_enable && io_strobe)
			kbd_byte <= io_din[7:0];
	end

	// long frames saturate instead of restarting at the command slot
	a_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(io_enable && (word_cnt != '0)) ##1 io_enable |-> (word_cnt != '0));

endmodule

`default_nettype wire

/* design/hps_file_pkg.sv */
`default_nettype none

package hps_file_pkg;

	//////////////////////////////
	// file transfer command codes
	localparam logic [15:0] fio_file_tx     = 16'h0053;
	localparam logic [15:0] fio_file_tx_dat = 16'h0054;
	localparam logic [15:0] fio_file_index  = 16'h0055;

	// download address, 16 low bits plus 11 upper bits
	localparam int ioctl_addr_w = 27;

endpackage

`default_nettype wire

/* design/hps_cmd_pkg.sv */
`default_nettype none

package hps_cmd_pkg;

	// bus and register widths
	localparam int word_w   = 16;
	localparam int status_w = 128;
	localparam int joy_w    = 32;

	//////////////////////////////
	// user io command codes
	localparam logic [word_w-1:0] cmd_config     = 16'h0001;
	localparam logic [word_w-1:0] cmd_joy0       = 16'h0002;
	localparam logic [word_w-1:0] cmd_joy1       = 16'h0003;
	localparam logic [word_w-1:0] cmd_kbd        = 16'h0005;
	localparam logic [word_w-1:0] cmd_status     = 16'h001e;
	localparam logic [word_w-1:0] cmd_status_set = 16'h0029;

	localparam logic [3:0] status_set_tag = 4'ha;
	// upper byte of a word the host wants dropped
	localparam logic [7:0] skip_marker    = 8'hff;

	//////////////////////////////
	// key event layout
	localparam int key_code_w      = 11;
	localparam int key_toggle_bit  = 10;
	localparam int key_pressed_bit = 9;
	localparam int key_ext_bit     = 8;
	localparam logic [7:0] kbd_ext_prefix     = 8'he0;
	localparam logic [7:0] kbd_release_prefix = 8'hf0;

endpackage

`default_nettype wire
